// ==== fill_check_pkg.sv ====
/* Shared widths, command, bus and result types for the fill-and-verify engine.
   Also holds the pattern step rule used by the generator and the testbench. */
`default_nettype none

package fill_check_pkg;

    // Bus and index widths
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;
    localparam int idx_width  = 16;
    // One extra bit so a full 65536-word count fits
    localparam int cnt_width  = idx_width + 1;

    // Galois LFSR feedback taps
    localparam logic [data_width-1:0] lfsr_taps = 32'h80200003;

    typedef enum logic {
        mode_fill   = 1'b0,
        mode_verify = 1'b1
    } cmd_mode_t;

    // Host command, sampled on start
    typedef struct packed {
        cmd_mode_t               mode;
        logic [idx_width-1:0]    base;
        logic [cnt_width-1:0]    count;
        logic [data_width-1:0]   seed;
        logic [strb_width-1:0]   lane_mask;
    } fill_cmd_t;

    // One bus transaction from the FSM to the master port
    typedef struct packed {
        logic                    is_write;
        logic [idx_width-1:0]    addr;
        logic [data_width-1:0]   wdata;
        logic [strb_width-1:0]   wstrb;
    } axil_req_t;

    // Completion pulses back from the master port
    typedef struct packed {
        logic                    wr_done;
        logic                    rd_valid;
        logic [data_width-1:0]   rdata;
    } axil_rsp_t;

    // first_err_index only meaningful when err_count is nonzero
    typedef struct packed {
        logic [cnt_width-1:0]    err_count;
        logic [idx_width-1:0]    first_err_index;
    } check_result_t;

    // Shift right, fold taps back in when a one drops out
    function automatic logic [data_width-1:0] lfsr_next(input logic [data_width-1:0] state);
        logic [data_width-1:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ lfsr_taps;
        end
        return shifted;
    endfunction

endpackage

`default_nettype wire

// ==== axil_ram.sv ====
/* AXI4-Lite RAM slave addressed by word index, with byte write strobes.
   Responses are always OKAY; PIPELINE_OUTPUT adds one register stage on read data. */
`timescale 1ns/1ps
`default_nettype none

module axil_ram import fill_check_pkg::*; #(
    parameter int MEM_WORDS_LOG2  = 10,
    parameter int PIPELINE_OUTPUT = 0
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [idx_width-1:0]  awaddr,
    input  wire logic                  awvalid,
    output logic                       awready,
    input  wire logic [data_width-1:0] wdata,
    input  wire logic [strb_width-1:0] wstrb,
    input  wire logic                  wvalid,
    output logic                       wready,
    output logic                       bvalid,
    input  wire logic                  bready,
    input  wire logic [idx_width-1:0]  araddr,
    input  wire logic                  arvalid,
    output logic                       arready,
    output logic [data_width-1:0]      rdata,
    output logic                       rvalid,
    input  wire logic                  rready
);

    localparam int  mem_words = 2 ** MEM_WORDS_LOG2;
    localparam bit  pipe_en   = (PIPELINE_OUTPUT != 0);

    // Starts out zeroed
    logic [data_width-1:0] mem [mem_words] = '{default: '0};

    logic                  wr_en;
    logic                  rd_en;
    logic                  rd_take;
    logic                  rvalid_q;
    logic                  rvalid_pipe_q;
    logic [data_width-1:0] rdata_q;
    logic [data_width-1:0] rdata_pipe_q;

    // Write needs both valids and a free response slot
    assign wr_en = awvalid && wvalid && (!bvalid || bready) && !awready && !wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= wr_en;
            wready  <= wr_en;
            bvalid  <= wr_en || (bvalid && !bready);
        end
    end

    // Only strobed byte lanes change
    always_ff @(posedge clk) begin
        for (int i = 0; i < strb_width; i++) begin
            if (wr_en && wstrb[i]) begin
                mem[awaddr[MEM_WORDS_LOG2-1:0]][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // First read stage drains into the pipe stage or straight to the master
    assign rd_take = pipe_en ? (!rvalid_pipe_q || rready) : rready;
    assign rd_en   = arvalid && (!rvalid_q || rd_take) && !arready;

    always_ff @(posedge clk) begin
        if (rst) begin
            arready       <= 1'b0;
            rvalid_q      <= 1'b0;
            rvalid_pipe_q <= 1'b0;
        end else begin
            arready  <= rd_en;
            rvalid_q <= rd_en || (rvalid_q && !rd_take);
            if (!rvalid_pipe_q || rready) begin
                rvalid_pipe_q <= rvalid_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_q <= mem[araddr[MEM_WORDS_LOG2-1:0]];
        end
        if (!rvalid_pipe_q || rready) begin
            rdata_pipe_q <= rdata_q;
        end
    end

    assign rdata  = pipe_en ? rdata_pipe_q : rdata_q;
    assign rvalid = pipe_en ? rvalid_pipe_q : rvalid_q;

    // A write response only comes with a completed address and data handshake
    a_bvalid_after_write: assert property (@(posedge clk) disable iff (rst)
        $rose(bvalid) |-> awvalid && awready && wvalid && wready);

    // Read data held until the master takes it
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid);

endmodule

`default_nettype wire

// ==== word_counter.sv ====
/* Tracks the current word index and words left in the active command.
   Index wraps at RAM depth; last and empty steer the sequencer. */
`timescale 1ns/1ps
`default_nettype none

module word_counter import fill_check_pkg::*; #(
    parameter int MEM_WORDS_LOG2 = 10
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 load,
    input  wire logic [idx_width-1:0] base,
    input  wire logic [cnt_width-1:0] count,
    input  wire logic                 step,
    output logic [idx_width-1:0]      index,
    output logic                      last,
    output logic                      empty
);

    logic [MEM_WORDS_LOG2-1:0] idx_q;
    logic [cnt_width-1:0]      remain_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            idx_q    <= '0;
            remain_q <= '0;
        end else if (load) begin
            idx_q    <= base[MEM_WORDS_LOG2-1:0];
            remain_q <= count;
        end else if (step) begin
            // Natural overflow gives the wrap
            idx_q    <= idx_q + 1'b1;
            remain_q <= remain_q - 1'b1;
        end
    end

    assign index = idx_width'(idx_q);
    assign last  = (remain_q == cnt_width'(1));
    assign empty = (remain_q == '0);

endmodule

`default_nettype wire

// ==== pattern_gen.sv ====
/* Pattern source for fill and verify, one LFSR word per step.
   Word is valid the cycle after load and tracks each step. */
`timescale 1ns/1ps
`default_nettype none

module pattern_gen import fill_check_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  load,
    input  wire logic [data_width-1:0] seed,
    input  wire logic                  step,
    output logic [data_width-1:0]      word
);

    logic [data_width-1:0] state;
    logic [data_width-1:0] seed_fixed;

    // An all-zero state would lock up
    assign seed_fixed = (seed == '0) ? data_width'(1) : seed;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= data_width'(1);
        end else if (load) begin
            // First step folded into load so word 0 is ready at once
            state <= lfsr_next(seed_fixed);
        end else if (step) begin
            state <= lfsr_next(state);
        end
    end

    assign word = state;

endmodule

`default_nettype wire

// ==== axil_master_port.sv ====
/* AXI4-Lite master side for one transaction at a time.
   Takes a request pulse, runs the handshake, returns a single response pulse. */
`timescale 1ns/1ps
`default_nettype none

module axil_master_port import fill_check_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  req_valid,
    input  wire axil_req_t             req,
    output logic                       busy_bus,
    output axil_rsp_t                  rsp,
    output logic [idx_width-1:0]       awaddr,
    output logic                       awvalid,
    input  wire logic                  awready,
    output logic [data_width-1:0]      wdata,
    output logic [strb_width-1:0]      wstrb,
    output logic                       wvalid,
    input  wire logic                  wready,
    input  wire logic                  bvalid,
    output logic                       bready,
    output logic [idx_width-1:0]       araddr,
    output logic                       arvalid,
    input  wire logic                  arready,
    input  wire logic [data_width-1:0] rdata,
    input  wire logic                  rvalid,
    output logic                       rready
);

    logic                  rdy_q;
    logic                  wr_done_q;
    logic                  rd_valid_q;
    logic [data_width-1:0] rdata_q;
    logic                  b_hs;
    logic                  r_hs;

    assign b_hs = bvalid && bready;
    assign r_hs = rvalid && rready;

    // Ready held high once out of reset
    assign bready = rdy_q;
    assign rready = rdy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_q      <= 1'b0;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            arvalid    <= 1'b0;
            busy_bus   <= 1'b0;
            wr_done_q  <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            rdy_q      <= 1'b1;
            wr_done_q  <= b_hs;
            rd_valid_q <= r_hs;
            if (req_valid) begin
                awvalid  <= req.is_write;
                wvalid   <= req.is_write;
                arvalid  <= !req.is_write;
                busy_bus <= 1'b1;
            end else begin
                // Each valid drops on its own handshake
                awvalid <= awvalid && !awready;
                wvalid  <= wvalid && !wready;
                arvalid <= arvalid && !arready;
                if (b_hs || r_hs) begin
                    busy_bus <= 1'b0;
                end
            end
        end
    end

    // Request and read payload
    always_ff @(posedge clk) begin
        if (req_valid) begin
            awaddr <= req.addr;
            araddr <= req.addr;
            wdata  <= req.wdata;
            wstrb  <= req.wstrb;
        end
        if (r_hs) begin
            rdata_q <= rdata;
        end
    end

    assign rsp = '{wr_done: wr_done_q, rd_valid: rd_valid_q, rdata: rdata_q};

    // Sequencer keeps a single transaction outstanding
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !busy_bus);

endmodule

`default_nettype wire

// ==== fill_check_fsm.sv ====
/* Command sequencer: one bus transaction per word, write for fill, read and compare
   for verify. Counts mismatching words and keeps the first failing index. */
`timescale 1ns/1ps
`default_nettype none

module fill_check_fsm import fill_check_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  start,
    input  wire fill_cmd_t             cmd,
    input  wire logic [idx_width-1:0]  index,
    input  wire logic                  last,
    input  wire logic                  empty,
    input  wire logic [data_width-1:0] word,
    input  wire axil_rsp_t             rsp,
    output logic                       cnt_load,
    output logic                       cnt_step,
    output logic                       pat_load,
    output logic                       pat_step,
    output logic                       req_valid,
    output axil_req_t                  req,
    output logic                       busy,
    output logic                       done,
    output check_result_t              result
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait,
        st_finish
    } state_t;

    state_t                state;
    cmd_mode_t             mode_q;
    logic [strb_width-1:0] mask_q;
    logic [data_width-1:0] lane_bits;
    logic                  rsp_hit;
    logic                  mismatch;

    // Byte mask widened to bit mask
    always_comb begin
        for (int i = 0; i < strb_width; i++) begin
            lane_bits[8*i +: 8] = {8{mask_q[i]}};
        end
    end

    assign rsp_hit  = rsp.wr_done || rsp.rd_valid;
    assign mismatch = |((rsp.rdata ^ word) & lane_bits);

    // Counter and generator load straight from the host command
    assign cnt_load  = start && (state == st_idle);
    assign pat_load  = cnt_load;
    assign cnt_step  = (state == st_wait) && rsp_hit;
    assign pat_step  = cnt_step;
    assign req_valid = (state == st_issue) && !empty;
    assign busy      = (state != st_idle);
    assign done      = (state == st_finish);

    // Same request shape for both modes, strobes unused on reads
    assign req = '{is_write: (mode_q == mode_fill), addr: index, wdata: word, wstrb: mask_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= st_idle;
            mode_q           <= mode_fill;
            mask_q           <= '0;
            result.err_count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        mode_q           <= cmd.mode;
                        mask_q           <= cmd.lane_mask;
                        result.err_count <= '0;
                        state            <= st_issue;
                    end
                end
                // Zero count skips the bus entirely
                st_issue: state <= empty ? st_finish : st_wait;
                st_wait: begin
                    if (rsp.rd_valid && mismatch) begin
                        result.err_count <= result.err_count + 1'b1;
                    end
                    if (rsp_hit) begin
                        state <= last ? st_finish : st_issue;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Index of the first failing word
    always_ff @(posedge clk) begin
        if (state == st_wait && rsp.rd_valid && mismatch && result.err_count == '0) begin
            result.first_err_index <= index;
        end
    end

endmodule

`default_nettype wire

// ==== fill_check_top.sv ====
/* Fill-and-verify engine around an AXI4-Lite RAM.
   Host pulses start with a command and waits for done; result holds until next start. */
`timescale 1ns/1ps
`default_nettype none

module fill_check_top import fill_check_pkg::*; #(
    parameter int MEM_WORDS_LOG2  = 10,
    parameter int PIPELINE_OUTPUT = 0
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      start,
    input  wire fill_cmd_t cmd,
    output logic           busy,
    output logic           done,
    output check_result_t  result
);

    // Sequencer side
    logic                  cnt_load;
    logic                  cnt_step;
    logic                  pat_load;
    logic                  pat_step;
    logic                  req_valid;
    axil_req_t             req;
    axil_rsp_t             rsp;
    logic [idx_width-1:0]  index;
    logic                  last;
    logic                  empty;
    logic [data_width-1:0] word;

    // AXI4-Lite between master port and RAM
    logic [idx_width-1:0]  awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;
    logic [idx_width-1:0]  araddr;
    logic                  arvalid;
    logic                  arready;
    logic [data_width-1:0] rdata;
    logic                  rvalid;
    logic                  rready;

    fill_check_fsm i_fsm (
        .clk, .rst, .start, .cmd, .index, .last, .empty, .word, .rsp,
        .cnt_load, .cnt_step, .pat_load, .pat_step, .req_valid, .req,
        .busy, .done, .result
    );

    word_counter #(.MEM_WORDS_LOG2(MEM_WORDS_LOG2)) i_counter (
        .clk, .rst, .load(cnt_load), .base(cmd.base), .count(cmd.count),
        .step(cnt_step), .index, .last, .empty
    );

    pattern_gen i_pattern (
        .clk, .rst, .load(pat_load), .seed(cmd.seed), .step(pat_step), .word
    );

    // Bus busy flag only feeds the port's own check
    axil_master_port i_master (
        .clk, .rst, .req_valid, .req, .busy_bus(), .rsp,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rvalid, .rready
    );

    axil_ram #(
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
        .PIPELINE_OUTPUT(PIPELINE_OUTPUT)
    ) i_ram (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rvalid, .rready
    );

endmodule

`default_nettype wire

// ==== tb_fill_check.sv ====
/* Directed testbench for the fill-and-verify engine with a RAM and pattern model.
   Set PIPELINE_OUTPUT to 1 to run the same tests against the pipelined RAM read path. */
`timescale 1ns/1ps
`default_nettype none

module tb_fill_check import fill_check_pkg::*; #(
    parameter int PIPELINE_OUTPUT = 0
);

    localparam int MEM_WORDS_LOG2 = 10;
    localparam int mem_words      = 2 ** MEM_WORDS_LOG2;

    // Word counts per test
    localparam int n_zeroed  = 16;
    localparam int n_fill    = 32;
    localparam int n_partial = 24;
    localparam int n_overlap = 20;
    localparam int n_busy    = 12;
    localparam int total_words = n_zeroed + 4 * n_fill + 2 * n_partial + 3 * n_overlap + n_busy;
    localparam int cycle_limit = total_words * 8 + 200;

    logic          clk;
    logic          rst;
    logic          start;
    fill_cmd_t     cmd;
    logic          busy;
    logic          done;
    check_result_t result;

    // Reference copy of the RAM contents
    logic [data_width-1:0] model_mem [mem_words];

    int     result_errors;
    int     timing_errors;
    int     cycles;
    integer rand_seed;

    fill_check_top #(
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
        .PIPELINE_OUTPUT(PIPELINE_OUTPUT)
    ) i_dut (
        .clk(clk), .rst(rst), .start(start), .cmd(cmd),
        .busy(busy), .done(done), .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

    // Galois step, seed zero handled by caller
    function automatic logic [data_width-1:0] next_pattern(input logic [data_width-1:0] s);
        logic [data_width-1:0] n;
        n = {1'b0, s[data_width-1:1]};
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    function automatic fill_cmd_t make_cmd(input cmd_mode_t mode, input int base, input int count,
                                           input logic [31:0] seed, input logic [3:0] mask);
        fill_cmd_t c;
        c.mode      = mode;
        c.base      = idx_width'(base % mem_words);
        c.count     = cnt_width'(count);
        c.seed      = seed;
        c.lane_mask = mask;
        return c;
    endfunction

    // Applies a fill to the model, or predicts a verify result
    task automatic model_run(input fill_cmd_t c, output check_result_t exp);
        logic [data_width-1:0] state;
        logic [data_width-1:0] bits;
        int                    idx;
        state = (c.seed == '0) ? 32'd1 : c.seed;
        exp   = '0;
        for (int i = 0; i < strb_width; i++) begin
            bits[8*i +: 8] = {8{c.lane_mask[i]}};
        end
        for (int k = 0; k < int'(c.count); k++) begin
            state = next_pattern(state);
            idx   = (int'(c.base) + k) % mem_words;
            if (c.mode == mode_fill) begin
                model_mem[idx] = (model_mem[idx] & ~bits) | (state & bits);
            end else if (((model_mem[idx] ^ state) & bits) != '0) begin
                // Only the first failing word keeps its index
                if (exp.err_count == '0) begin
                    exp.first_err_index = idx_width'(idx);
                end
                exp.err_count = exp.err_count + 1'b1;
            end
        end
    endtask

    task automatic check_result(input string what, input check_result_t got,
                                input check_result_t exp);
        if (got.err_count !== exp.err_count) begin
            $display("Error: %s result.err_count got %h expected %h",
                     what, got.err_count, exp.err_count);
            result_errors++;
        end else if (exp.err_count != '0 && got.first_err_index !== exp.first_err_index) begin
            $display("Error: %s result.first_err_index got %h expected %h",
                     what, got.first_err_index, exp.first_err_index);
            result_errors++;
        end
    endtask

    task automatic check_done_timing(input string what, input logic exp_busy,
                                     input logic exp_done);
        if (busy !== exp_busy) begin
            $display("Error: %s busy got %h expected %h", what, busy, exp_busy);
            timing_errors++;
        end
        if (done !== exp_done) begin
            $display("Error: %s done got %h expected %h", what, done, exp_done);
            timing_errors++;
        end
    endtask

    // One-cycle start, then busy must be up
    task automatic launch(input string what, input fill_cmd_t c);
        @(negedge clk);
        cmd   = c;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_done_timing({what, " after start"}, 1'b1, 1'b0);
    endtask

    task automatic finish_cmd(input string what, input fill_cmd_t c);
        check_result_t exp;
        while (!done) begin
            @(negedge clk);
        end
        model_run(c, exp);
        check_result(what, result, exp);
    endtask

    task automatic do_cmd(input string what, input fill_cmd_t c);
        launch(what, c);
        finish_cmd(what, c);
    endtask

    // Verify over untouched, zeroed memory
    task automatic test_zeroed_verify();
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  m;
        r = $random(rand_seed);
        s = $random(rand_seed) | 32'd1;
        m = (r[7:4] == '0) ? 4'hf : r[7:4];
        do_cmd("zeroed verify", make_cmd(mode_verify, int'(r[15:0]), n_zeroed, s, m));
    endtask

    // Fill then verify, once in the middle and once across the top
    task automatic test_fill_verify(input string what, input int base);
        logic [31:0] s;
        s = $random(rand_seed);
        do_cmd({what, " fill"}, make_cmd(mode_fill, base, n_fill, s, 4'hf));
        do_cmd({what, " verify"}, make_cmd(mode_verify, base, n_fill, s, 4'hf));
    endtask

    task automatic test_partial_mask();
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  m;
        r = $random(rand_seed);
        s = $random(rand_seed);
        // Mask between 1 and 14, never all lanes
        m = 4'((r % 14) + 1);
        do_cmd("partial fill", make_cmd(mode_fill, int'(r[25:10]), n_partial, s, m));
        do_cmd("partial verify", make_cmd(mode_verify, int'(r[25:10]), n_partial, s, 4'hf));
    endtask

    task automatic test_overlap(output int base, output logic [31:0] seed_b);
        logic [31:0] r;
        logic [31:0] seed_a;
        r      = $random(rand_seed);
        seed_a = $random(rand_seed);
        seed_b = seed_a ^ 32'h5a5a_0f0f;
        base   = int'(r[15:0]) % mem_words;
        do_cmd("overlap fill a", make_cmd(mode_fill, base, n_overlap, seed_a, 4'hf));
        do_cmd("overlap fill b", make_cmd(mode_fill, base + n_overlap / 2, n_overlap,
                                          seed_b, 4'hf));
        do_cmd("overlap verify", make_cmd(mode_verify, base, n_overlap, seed_a, 4'hf));
    endtask

    task automatic test_zero_count();
        check_result_t exp;
        fill_cmd_t     c;
        c = make_cmd(mode_verify, 5, 0, 32'h1234, 4'hf);
        launch("zero count", c);
        @(negedge clk);
        check_done_timing("zero count done cycle", 1'b1, 1'b1);
        model_run(c, exp);
        check_result("zero count", result, exp);
        @(negedge clk);
        check_done_timing("zero count idle", 1'b0, 1'b0);
    endtask

    // Second start during a running verify must not be taken
    task automatic test_busy_start(input int base, input logic [31:0] seed);
        fill_cmd_t c;
        c = make_cmd(mode_verify, base, n_busy, seed, 4'hf);
        launch("busy start", c);
        repeat (3) @(negedge clk);
        check_done_timing("busy start while running", 1'b1, 1'b0);
        cmd   = make_cmd(mode_fill, base, 5, ~seed, 4'hf);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        finish_cmd("busy start", c);
        repeat (3) begin
            @(negedge clk);
            check_done_timing("busy start afterwards", 1'b0, 1'b0);
        end
    endtask

    initial begin
        int          ov_base;
        logic [31:0] ov_seed;
        rand_seed     = 32471;
        result_errors = 0;
        timing_errors = 0;
        rst   = 1'b1;
        start = 1'b0;
        cmd   = '0;
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Quiet after reset
        repeat (4) begin
            @(negedge clk);
            check_done_timing("after reset", 1'b0, 1'b0);
        end

        test_zeroed_verify();
        test_fill_verify("mid range", 100);
        test_fill_verify("wrap", mem_words - n_fill / 2);
        test_partial_mask();
        test_overlap(ov_base, ov_seed);
        test_zero_count();
        test_busy_start(ov_base, ov_seed);

        repeat (2) @(negedge clk);
        $display("Result errors: %0d, timing errors: %0d", result_errors, timing_errors);
        if (result_errors == 0 && timing_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
fill_check_pkg.sv
axil_ram.sv
word_counter.sv
pattern_gen.sv
axil_master_port.sv
fill_check_fsm.sv
fill_check_top.sv
tb_fill_check.sv

// ==== Makefile ====
# PIPE=1 rebuilds with the pipelined RAM read path
PIPE ?= 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench (make test PIPE=1 for pipelined RAM output)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fill_check \
		-GPIPELINE_OUTPUT=$(PIPE) -f verilog.f --Mdir obj_dir
	./obj_dir/Vtb_fill_check | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
